// ==== fetch_pkg.sv ====
// shared widths and types for the fetch front end; RV64I only, no compressed instructions
`default_nettype none

package fetch_pkg;

  localparam int INST_WD      = 32;
  localparam int PC_WD        = 64;
  localparam int SRAM_ADDR_WD = 64;
  localparam int SRAM_DATA_WD = 64;  // two instructions per read

  localparam logic [PC_WD-1:0] PC_RESET_VAL = 64'h8000_0000;
  localparam logic [PC_WD-1:0] PC_STEP      = 64'd4;

  // major opcodes, bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b000_0011,
    OPC_OP_IMM    = 7'b001_0011,
    OPC_AUIPC     = 7'b001_0111,
    OPC_OP_IMM_32 = 7'b001_1011,
    OPC_STORE     = 7'b010_0011,
    OPC_OP        = 7'b011_0011,
    OPC_LUI       = 7'b011_0111,
    OPC_OP_32     = 7'b011_1011,
    OPC_BRANCH    = 7'b110_0011,
    OPC_JAL       = 7'b110_1111
  } opcode_e;

  // class seen by later stages
  // lui and auipc count as alu work
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_LOAD   = 3'd1,
    OP_STORE  = 3'd2,
    OP_BRANCH = 3'd3,
    OP_JAL    = 3'd4,
    OP_OTHER  = 3'd5
  } op_class_e;

  // redirect from decode back to the pc generator
  typedef struct packed {
    logic             br_taken;   // one cycle per jal
    logic [PC_WD-1:0] br_target;
  } br_bus_t;

endpackage

`default_nettype wire

// ==== fetch_top.sv ====
// fetch front end top; sram must answer one cycle after ren and hold rdata while ren is low
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  // inst sram
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                    i_inst_sram_rw_ready,
  // to execute
  input  logic                    i_es_allowin,
  output logic                    o_ds_valid,
  output logic [PC_WD-1:0]        o_ds_pc,
  output logic [INST_WD-1:0]      o_ds_inst,
  output op_class_e               o_ds_op
);

  br_bus_t br_bus;  // decode back to fetch

  fs_ds_if u_fs_ds ();

  if_stage u_if_stage (
    .i_clk                (i_clk),
    .i_rst                (i_rst),
    .i_br                 (br_bus),
    .i_inst_sram_rdata    (i_inst_sram_rdata),
    .i_inst_sram_rw_ready (i_inst_sram_rw_ready),
    .o_inst_sram_ren      (o_inst_sram_ren),
    .o_inst_sram_addr     (o_inst_sram_addr),
    .fs                   (u_fs_ds.fs)
  );

  id_stage u_id_stage (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .ds           (u_fs_ds.ds),
    .i_es_allowin (i_es_allowin),
    .o_br         (br_bus),
    .o_ds_valid   (o_ds_valid),
    .o_ds_pc      (o_ds_pc),
    .o_ds_inst    (o_ds_inst),
    .o_ds_op      (o_ds_op)
  );

endmodule

`default_nettype wire

// ==== fs_ds_if.sv ====
// fetch to decode hand-off; a word moves on a clock edge where valid and allowin are both high
`default_nettype none

interface fs_ds_if import fetch_pkg::*; ();

  logic               valid;    // fetch holds a live word
  logic [INST_WD-1:0] inst;
  logic [PC_WD-1:0]   pc;
  logic               allowin;  // decode can take it

  // fetch side
  modport fs (
    output valid,
    output inst,
    output pc,
    input  allowin
  );

  // decode side
  modport ds (
    input  valid,
    input  inst,
    input  pc,
    output allowin
  );

endinterface

`default_nettype wire

// ==== id_stage.sv ====
// decode stage; classifies by major opcode only, resolves jal here, branches fall through
`default_nettype none

module id_stage import fetch_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  fs_ds_if.ds                ds,
  input  logic               i_es_allowin,
  output br_bus_t            o_br,
  output logic               o_ds_valid,
  output logic [PC_WD-1:0]   o_ds_pc,
  output logic [INST_WD-1:0] o_ds_inst,
  output op_class_e          o_ds_op
);

  logic               ds_valid;
  logic               ds_allowin;
  logic               ds_leave;     // contents move on this cycle
  logic [PC_WD-1:0]   ds_pc;
  logic [INST_WD-1:0] ds_inst;
  logic [PC_WD-1:0]   j_imm;
  op_class_e          ds_op;

  assign ds_allowin  = ~ds_valid | i_es_allowin;
  assign ds_leave    = ds_valid & i_es_allowin;
  assign ds.allowin  = ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= ds.valid;  // already low for a squashed word
    end
  end

  // pipeline payload
  always_ff @(posedge i_clk) begin
    if (ds.valid && ds_allowin) begin
      ds_pc   <= ds.pc;
      ds_inst <= ds.inst;
    end
  end

  always_comb begin
    case (ds_inst[6:0])
      OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32, OPC_LUI, OPC_AUIPC: begin
        ds_op = OP_ALU;
      end
      OPC_LOAD: begin
        ds_op = OP_LOAD;
      end
      OPC_STORE: begin
        ds_op = OP_STORE;
      end
      OPC_BRANCH: begin
        ds_op = OP_BRANCH;  // treated as not taken
      end
      OPC_JAL: begin
        ds_op = OP_JAL;
      end
      default: begin
        ds_op = OP_OTHER;
      end
    endcase
  end

  // j-type immediate with bit 0 always zero
  assign j_imm = {{(PC_WD-21){ds_inst[31]}}, ds_inst[31], ds_inst[19:12],
                  ds_inst[20], ds_inst[30:21], 1'b0};

  // fires once, in the cycle the jal leaves
  assign o_br.br_taken  = ds_leave & (ds_op == OP_JAL);
  assign o_br.br_target = ds_pc + j_imm;

  assign o_ds_valid = ds_valid;
  assign o_ds_pc    = ds_pc;
  assign o_ds_inst  = ds_inst;
  assign o_ds_op    = ds_op;

  a_br_needs_valid: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_br.br_taken |-> o_ds_valid
  ) else $error("id_stage: redirect without a valid decode word");

  // fetch must squash its word, so decode is empty right after a redirect
  a_br_squash: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_br.br_taken |=> !o_ds_valid
  ) else $error("id_stage: wrong-path word entered decode after jal at %h", $past(ds_pc));

endmodule

`default_nettype wire

// ==== if_stage.sv ====
// fetch stage; needs sram rdata to hold while ren is low, one request in flight at most
`default_nettype none

module if_stage import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  br_bus_t                 i_br,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                    i_inst_sram_rw_ready,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  fs_ds_if.fs                     fs
);

  // pre-fetch side
  logic               to_fs_valid;   // a new request can go out
  logic               fs_load;

  // fetch side
  logic               fs_valid;
  logic               fs_allowin;
  logic [PC_WD-1:0]   fs_pc;
  logic [INST_WD-1:0] fs_inst;

  assign to_fs_valid = ~i_rst & i_inst_sram_rw_ready;

  // empty, or the current word moves into decode this cycle
  assign fs_allowin  = ~fs_valid | fs.allowin;
  assign fs_load     = to_fs_valid & fs_allowin;

  // a redirect only fires while decode empties, so fetch allows in that cycle.
  // the valid bit then either clears or belongs to the target's fetch
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_load           (fs_load),
    .i_br             (i_br),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // sram lines are 64 bits wide and pc bit 2 picks the half
  always_comb begin
    if (fs_pc[2]) begin
      fs_inst = i_inst_sram_rdata[SRAM_DATA_WD-1 -: INST_WD];
    end else begin
      fs_inst = i_inst_sram_rdata[INST_WD-1:0];
    end
  end

  // the word in fetch is wrong-path whenever decode redirects
  assign fs.valid = fs_valid & ~i_br.br_taken;
  assign fs.inst  = fs_inst;
  assign fs.pc    = fs_pc;

  // stalled word must not change
  // relies on the pc holding and on the sram keeping rdata without ren
  a_fs_hold: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (fs_valid && !fs_allowin) |=> (fs_valid && $stable(fs_inst) && $stable(fs_pc))
  ) else $error("if_stage: stalled fetch word changed, pc=%h", fs_pc);

endmodule

`default_nettype wire

// ==== pc_gen.sv ====
// pc generator; the sram samples addr on the edge where the pc moves and pc holds the last request
`default_nettype none

module pc_gen import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_load,            // fetch issues a request this cycle
  input  br_bus_t                 i_br,
  output logic [PC_WD-1:0]        o_pc,
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [PC_WD-1:0] pc_q;     // address of the last request
  logic [PC_WD-1:0] next_pc;

  // redirect wins over the sequential step
  assign next_pc = i_br.br_taken ? i_br.br_target : pc_q + PC_STEP;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= PC_RESET_VAL - PC_STEP;  // first request lands on the reset vector
    end else if (i_load) begin
      pc_q <= next_pc;
    end else if (i_br.br_taken) begin
      // no request went out with the redirect
      // park one word short so the next step hits the target
      pc_q <= i_br.br_target - PC_STEP;
    end
  end

  assign o_pc             = pc_q;
  assign o_inst_sram_ren  = i_load;
  assign o_inst_sram_addr = next_pc[SRAM_ADDR_WD-1:0];  // request goes out with the update

  // jal targets come from decode
  // a misaligned one would break the word select in fetch
  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (i_rst)
    pc_q[1:0] == 2'b00
  ) else $error("pc_gen: pc not word aligned, pc=%h", pc_q);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the fetch front end testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --assert --top-module tb_fetch_top -f vlog.f -o sim_fetch
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_fetch 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb_fetch_top.sv ====
// sram answers one cycle after ren and holds rdata otherwise; program is 8 KiB at the reset vector
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

  localparam int N_EXP     = 40;    // accepted instructions per stream
  localparam int N_STREAMS = 4;
  localparam int NW        = 2048;  // program words
  localparam int MEM_LINES = NW / 2;
  localparam int WD_CYCLES = 20 * N_EXP * N_STREAMS;

  logic                    i_clk;
  logic                    i_rst = 1'b1;
  logic                    o_inst_sram_ren;
  logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr;
  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata = '0;
  logic                    i_inst_sram_rw_ready = 1'b1;
  logic                    i_es_allowin = 1'b1;
  logic                    o_ds_valid;
  logic [PC_WD-1:0]        o_ds_pc;
  logic [INST_WD-1:0]      o_ds_inst;
  op_class_e               o_ds_op;

  logic [INST_WD-1:0]      prog_word [NW];
  op_class_e               prog_cls  [NW];
  logic [PC_WD-1:0]        prog_off  [NW];   // jal offset in bytes
  logic [SRAM_DATA_WD-1:0] mem [MEM_LINES];
  logic [PC_WD-1:0]        exp_pc   [N_EXP];
  logic [INST_WD-1:0]      exp_inst [N_EXP];
  op_class_e               exp_op   [N_EXP];

  logic        stall_es   = 1'b0;
  logic        stall_sram = 1'b0;
  logic [31:0] lcg_state  = 32'h665b_a806;
  int          got_cnt    = 0;
  int          err_cmp    = 0;
  int          err_ren    = 0;
  int          err_rst    = 0;
  int          chk_cmp    = 0;
  int          chk_rst    = 0;
  int          test_cnt   = 0;
  int          fail_cnt   = 0;
  int          err_base   = 0;

  fetch_top i_dut (
    .i_clk                (i_clk),
    .i_rst                (i_rst),
    .o_inst_sram_ren      (o_inst_sram_ren),
    .o_inst_sram_addr     (o_inst_sram_addr),
    .i_inst_sram_rdata    (i_inst_sram_rdata),
    .i_inst_sram_rw_ready (i_inst_sram_rw_ready),
    .i_es_allowin         (i_es_allowin),
    .o_ds_valid           (o_ds_valid),
    .o_ds_pc              (o_ds_pc),
    .o_ds_inst            (o_ds_inst),
    .o_ds_op              (o_ds_op)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, 7'b001_0011};
  endfunction

  // jal x1 with the offset scattered into the j-type fields
  function automatic logic [31:0] jal_word(input longint off);
    logic [20:0] imm;
    imm = off[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b110_1111};
  endfunction

  function automatic int tot_err();
    return err_cmp + err_ren + err_rst;
  endfunction

  // next pc of the program walk, plus the word and its class at pc
  function automatic logic [PC_WD-1:0] ref_step(input logic [PC_WD-1:0] pc,
                                                output logic [INST_WD-1:0] inst,
                                                output op_class_e op);
    int k;
    k = int'((pc - PC_RESET_VAL) >> 2);
    inst = prog_word[k];
    op = prog_cls[k];
    if (prog_cls[k] == OP_JAL) begin
      return pc + prog_off[k];
    end else begin
      return pc + 64'd4;
    end
  endfunction

  task automatic put(input int k, input logic [31:0] w, input op_class_e c);
    prog_word[k] = w;
    prog_cls[k] = c;
    prog_off[k] = '0;
  endtask

  task automatic put_jal(input int k, input int tk);
    longint off;
    off = longint'(tk - k) << 2;
    prog_word[k] = jal_word(off);
    prog_cls[k] = OP_JAL;
    prog_off[k] = off;
  endtask

  task automatic load_program();
    logic [PC_WD-1:0] a;
    int k;
    for (k = 0; k < NW; k++) begin
      a = PC_RESET_VAL + (64'(k) << 2);
      put(k, ~(a[31:0] ^ {a[15:0], a[31:16]} ^ a[63:32]), OP_OTHER);
    end
    put(0, 32'h0010_0093, OP_ALU);     // addi x1, x0, 1
    put(1, 32'h0000_a103, OP_LOAD);    // lw x2, 0(x1)
    put(2, 32'h0020_a223, OP_STORE);   // sw x2, 4(x1)
    put(3, 32'h0020_8463, OP_BRANCH);  // beq falls through
    put(4, 32'h1234_51b7, OP_ALU);     // lui
    put_jal(5, 9);
    put(6, addi_word(5'd31, 12'd6), OP_ALU);  // wrong path from here to 8
    put(7, addi_word(5'd31, 12'd7), OP_ALU);
    put(8, addi_word(5'd31, 12'd8), OP_ALU);
    put(9, 32'h0020_8233, OP_ALU);     // add in the upper half of its line
    put(10, 32'h0080_b283, OP_LOAD);   // ld
    put_jal(11, 14);
    put(12, addi_word(5'd31, 12'd12), OP_ALU);
    put(13, addi_word(5'd31, 12'd13), OP_ALU);
    put_jal(14, 20);
    put(15, addi_word(5'd31, 12'd15), OP_ALU);
    put(16, 32'h0020_9463, OP_BRANCH);  // bne
    put(17, 32'h0000_1317, OP_ALU);     // auipc
    put_jal(18, 1042);                  // far jump with imm above bit 11
    put(19, addi_word(5'd31, 12'd19), OP_ALU);
    put(20, 32'h0030_839b, OP_ALU);     // addiw
    put(21, 32'h0071_3823, OP_STORE);   // sd
    put_jal(22, 16);                    // backward
    put(23, addi_word(5'd31, 12'd23), OP_ALU);
    put(1042, 32'h0071_01b3, OP_ALU);
    put_jal(1043, 25);
    put(25, 32'h4020_8233, OP_ALU);     // sub
    put(26, 32'h0ff0_000f, OP_OTHER);   // fence
    put_jal(27, 27);                    // self-loop at the end of the program
    for (k = 0; k < MEM_LINES; k++) begin
      mem[k] = {prog_word[2*k+1], prog_word[2*k]};
    end
  endtask

  task automatic build_expected();
    logic [PC_WD-1:0]   pc;
    logic [INST_WD-1:0] w;
    op_class_e          c;
    int i;
    pc = PC_RESET_VAL;
    for (i = 0; i < N_EXP; i++) begin
      exp_pc[i] = pc;
      pc = ref_step(pc, w, c);
      exp_inst[i] = w;
      exp_op[i] = c;
    end
  endtask

  // three reset cycles; outputs stay idle once the first edge has hit
  task automatic do_reset(input logic es_mode, input logic sram_mode);
    int i;
    i_rst <= 1'b1;
    stall_es <= es_mode;
    stall_sram <= sram_mode;
    for (i = 0; i < 3; i++) begin
      @(posedge i_clk);
      if (i > 0) begin
        chk_rst++;
        assert (!o_ds_valid && !o_inst_sram_ren) else begin
          $display("[FAIL] t=%0t ds_valid=%b ren=%b during reset", $time, o_ds_valid,
                   o_inst_sram_ren);
          err_rst++;
        end
      end
    end
    i_rst <= 1'b0;
  endtask

  task automatic end_test(input string name);
    int n;
    n = tot_err() - err_base;
    test_cnt++;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, n);
    end
    err_base = tot_err();
  endtask

  // sram model with one cycle latency and rdata held without ren
  always @(posedge i_clk) begin
    if (o_inst_sram_ren) begin
      i_inst_sram_rdata <= mem[o_inst_sram_addr[12:3]];
    end
  end

  always @(posedge i_clk) begin
    lcg_state = lcg_next(lcg_state);
    i_es_allowin         <= stall_es ? (lcg_state[31:30] != 2'b00) : 1'b1;
    i_inst_sram_rw_ready <= stall_sram ? (lcg_state[27:26] != 2'b00) : 1'b1;
  end

  always @(posedge i_clk) begin
    if (!i_rst) begin
      assert (!(o_inst_sram_ren && !i_inst_sram_rw_ready)) else begin
        $display("[FAIL] t=%0t sram request issued while rw_ready is low", $time);
        err_ren++;
      end
      if (o_inst_sram_ren) begin
        // every request must be word aligned and inside the program
        assert (o_inst_sram_addr[1:0] == 2'b00 && o_inst_sram_addr >= PC_RESET_VAL &&
                o_inst_sram_addr < PC_RESET_VAL + 64'(NW * 4)) else begin
          $display("[FAIL] t=%0t sram address %h outside the program", $time,
                   o_inst_sram_addr);
          err_ren++;
        end
      end
    end
  end

  // compare every accepted decode output with the reference walk
  always @(posedge i_clk) begin
    if (i_rst) begin
      got_cnt = 0;
    end else if (o_ds_valid && i_es_allowin && got_cnt < N_EXP) begin
      chk_cmp++;
      assert (o_ds_pc == exp_pc[got_cnt]) else begin
        $display("[FAIL] t=%0t entry %0d pc %h, expected %h", $time, got_cnt, o_ds_pc,
                 exp_pc[got_cnt]);
        err_cmp++;
      end
      assert (o_ds_inst == exp_inst[got_cnt]) else begin
        $display("[FAIL] t=%0t entry %0d inst %h, expected %h", $time, got_cnt, o_ds_inst,
                 exp_inst[got_cnt]);
        err_cmp++;
      end
      assert (o_ds_op == exp_op[got_cnt]) else begin
        $display("[FAIL] t=%0t entry %0d class %s, expected %s", $time, got_cnt,
                 o_ds_op.name(), exp_op[got_cnt].name());
        err_cmp++;
      end
      got_cnt++;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge i_clk);
    $display("timeout: decode delivered %0d of %0d instructions before %0d cycles ran out",
             got_cnt, N_EXP, WD_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    load_program();
    build_expected();
    do_reset(1'b0, 1'b0);
    end_test("reset_idle");
    wait (got_cnt == N_EXP);
    end_test("straight_and_jal");
    do_reset(1'b1, 1'b0);
    wait (got_cnt == N_EXP);
    end_test("es_backpressure");
    do_reset(1'b0, 1'b1);
    wait (got_cnt == N_EXP);
    end_test("sram_not_ready");
    do_reset(1'b1, 1'b1);
    wait (got_cnt == N_EXP);
    end_test("mixed_stalls");
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", test_cnt, fail_cnt,
             chk_cmp + chk_rst, tot_err());
    if (fail_cnt == 0 && tot_err() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
fetch_pkg.sv
fs_ds_if.sv
pc_gen.sv
if_stage.sv
id_stage.sv
fetch_top.sv
tb_fetch_top.sv
